//--- source/dcache_pkg.sv
// Data cache shared definitions
package dcache_pkg;

	// Address and data sizes
	localparam int ADDR_WIDTH = 16;
	localparam int DATA_WIDTH = 32;

	// Cache geometry
	localparam int INDEX_WIDTH = 4;
	localparam int OFFSET_WIDTH = 2;
	localparam int LINE_WORDS = 1 << OFFSET_WIDTH;
	localparam int NUM_LINES = 1 << INDEX_WIDTH;

	// Two low address bits select the byte in a word
	localparam int TAG_WIDTH = ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH - 2;

	typedef logic [ADDR_WIDTH - 1 : 0] addr_t;
	typedef logic [DATA_WIDTH - 1 : 0] word_t;
	typedef logic [TAG_WIDTH - 1 : 0] tag_t;
	typedef logic [INDEX_WIDTH - 1 : 0] index_t;
	typedef logic [OFFSET_WIDTH - 1 : 0] offset_t;
	typedef logic [LINE_WORDS - 1 : 0] beat_t;

	// Miss handling states
	typedef enum logic [1:0] {
		STATE_READY,
		STATE_FLUSH,
		STATE_WAIT,
		STATE_REFILL
	} dcache_state_t;

endpackage

//--- source/cache_bank.sv
// Synchronous cache storage bank
`timescale 1ns/1ps

module cache_bank #(
	parameter type payload_t = dcache_pkg::word_t
) (
	input  logic                clk,
	input  logic                i_we,
	input  dcache_pkg::index_t  i_waddr,
	input  dcache_pkg::index_t  i_raddr,
	input  payload_t            i_wdata,
	output payload_t            o_rdata
);

	// One entry per cache line
	payload_t mem [dcache_pkg::NUM_LINES];

	always_ff @(posedge clk)
	begin
		if (i_we)
			mem[i_waddr] <= i_wdata;
	end

	// Write-first read, so a fill is visible on the next cycle
	always_ff @(posedge clk)
	begin
		if (i_we && (i_waddr == i_raddr))
			o_rdata <= i_wdata;
		else
			o_rdata <= mem[i_raddr];
	end

endmodule

//--- source/line_beat_counter.sv
// Line beat counter
`timescale 1ns/1ps

module line_beat_counter (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 i_advance,
	output dcache_pkg::beat_t    o_select,
	output dcache_pkg::offset_t  o_beat,
	output logic                 o_last
);

	localparam int W = dcache_pkg::LINE_WORDS;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			o_select <= dcache_pkg::beat_t'(1);
		else if (i_advance)
			o_select <= {o_select[W - 2 : 0], o_select[W - 1]};
	end

	// Binary form of the current beat
	always_comb
	begin
		o_beat = '0;
		for (int i = 0; i < W; i++)
		begin
			if (o_select[i])
				o_beat = dcache_pkg::offset_t'(i);
		end
	end

	assign o_last = o_select[W - 1];

	select_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot(o_select))
		else $error("%m beat select lost its one-hot form");

endmodule

//--- source/dcache_flush_buffer.sv
// Dirty line flush buffer
`timescale 1ns/1ps

module dcache_flush_buffer (
	input  logic               clk,
	input  logic               i_load,
	input  dcache_pkg::word_t  i_line [dcache_pkg::LINE_WORDS],
	output dcache_pkg::word_t  o_word
);

	localparam int W = dcache_pkg::LINE_WORDS;

	dcache_pkg::word_t shift_words [W];

	always_ff @(posedge clk)
	begin
		if (i_load)
		begin
			for (int i = 0; i < W; i++)
				shift_words[i] <= i_line[i];
		end
		else
		begin
			// Lowest word leaves first
			for (int i = 0; i < W - 1; i++)
				shift_words[i] <= shift_words[i + 1];
		end
	end

	assign o_word = shift_words[0];

endmodule

//--- source/dcache_tag_store.sv
// Data cache tag store
`timescale 1ns/1ps

module dcache_tag_store (
	input  logic                clk,
	input  logic                rst_n,
	input  dcache_pkg::index_t  i_raddr,
	input  dcache_pkg::index_t  i_index,
	input  dcache_pkg::tag_t    i_tag,
	input  logic                i_mark_dirty,
	input  logic                i_fill,
	input  dcache_pkg::index_t  i_fill_index,
	input  dcache_pkg::tag_t    i_fill_tag,
	output logic                o_match,
	output logic                o_victim_dirty,
	output dcache_pkg::tag_t    o_victim_tag
);

	logic [dcache_pkg::NUM_LINES - 1 : 0] valid_bits;
	logic [dcache_pkg::NUM_LINES - 1 : 0] dirty_bits;
	dcache_pkg::tag_t tag_rdata;

	// Tags read through the look-ahead index
	cache_bank #(
		.payload_t (dcache_pkg::tag_t)
	) u_tag_bank (
		.clk,
		.i_we    (i_fill),
		.i_waddr (i_fill_index),
		.i_raddr (i_raddr),
		.i_wdata (i_fill_tag),
		.o_rdata (tag_rdata)
	);

	always_comb
	begin
		o_match = valid_bits[i_index] & (tag_rdata == i_tag);
		o_victim_dirty = valid_bits[i_index] & dirty_bits[i_index];
		o_victim_tag = tag_rdata;
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end
		else
		begin
			if (i_mark_dirty)
				dirty_bits[i_index] <= 1'b1;
			// A fresh line is clean
			if (i_fill)
			begin
				valid_bits[i_fill_index] <= 1'b1;
				dirty_bits[i_fill_index] <= 1'b0;
			end
		end
	end

endmodule

//--- source/dcache_ctrl.sv
// Data cache miss controller
`timescale 1ns/1ps

module dcache_ctrl (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                i_req_valid,
	input  logic                i_req_write,
	input  dcache_pkg::addr_t   i_req_addr,
	input  dcache_pkg::addr_t   i_req_addr_next,
	input  dcache_pkg::word_t   i_req_wdata,
	input  logic                i_match,
	input  logic                i_victim_dirty,
	input  dcache_pkg::tag_t    i_victim_tag,
	input  logic                i_beat_last,
	input  dcache_pkg::beat_t   i_beat_select,
	input  logic                i_mem_rd_done,
	input  logic                i_mem_rd_valid,
	input  dcache_pkg::word_t   i_mem_rd_data,
	input  logic                i_mem_wr_done,
	output logic                o_resp_valid,
	output dcache_pkg::index_t  o_index,
	output dcache_pkg::index_t  o_raddr,
	output dcache_pkg::tag_t    o_tag,
	output logic                o_mark_dirty,
	output logic                o_fill,
	output dcache_pkg::index_t  o_fill_index,
	output dcache_pkg::tag_t    o_fill_tag,
	output logic                o_advance,
	output logic                o_load,
	output dcache_pkg::beat_t   o_bank_we,
	output dcache_pkg::index_t  o_bank_waddr,
	output dcache_pkg::index_t  o_bank_raddr,
	output dcache_pkg::word_t   o_bank_wdata,
	output logic                o_mem_rd_go,
	output dcache_pkg::addr_t   o_mem_rd_base,
	output logic                o_mem_wr_go,
	output dcache_pkg::addr_t   o_mem_wr_base,
	output logic                o_mem_wr_valid
);

	localparam int LOW_BITS = dcache_pkg::OFFSET_WIDTH + 2;

	dcache_pkg::dcache_state_t state, next_state;
	dcache_pkg::tag_t req_tag, r_tag;
	dcache_pkg::index_t req_index, next_index, r_index;
	dcache_pkg::offset_t req_offset;
	logic hit, miss, refill_last;

	// Address fields of the current and the look-ahead request
	assign {req_tag, req_index, req_offset} = i_req_addr[dcache_pkg::ADDR_WIDTH - 1 : 2];
	assign next_index = i_req_addr_next[LOW_BITS +: dcache_pkg::INDEX_WIDTH];

	always_comb
	begin
		hit = i_req_valid & i_match & (state == dcache_pkg::STATE_READY);
		miss = i_req_valid & ~i_match & (state == dcache_pkg::STATE_READY);
		refill_last = i_mem_rd_valid & i_beat_last;
	end

	// Commands wait for the matching done
	always_comb
	begin
		next_state = state;
		unique case (state)
			dcache_pkg::STATE_READY:
			begin
				if (miss && i_victim_dirty && i_mem_wr_done)
					next_state = dcache_pkg::STATE_FLUSH;
				else if (miss && !i_victim_dirty && i_mem_rd_done)
					next_state = dcache_pkg::STATE_REFILL;
			end
			dcache_pkg::STATE_FLUSH:
			begin
				if (i_beat_last)
					next_state = dcache_pkg::STATE_WAIT;
			end
			dcache_pkg::STATE_WAIT:
			begin
				if (i_mem_wr_done && i_mem_rd_done)
					next_state = dcache_pkg::STATE_REFILL;
			end
			dcache_pkg::STATE_REFILL:
			begin
				if (refill_last)
					next_state = dcache_pkg::STATE_READY;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			state <= dcache_pkg::STATE_READY;
		else
			state <= next_state;
	end

	// Missing line held for the whole miss
	always_ff @(posedge clk)
	begin
		if (miss)
		begin
			r_tag <= req_tag;
			r_index <= req_index;
		end
	end

	always_comb
	begin
		o_resp_valid = hit;
		o_index = req_index;
		o_raddr = next_index;
		o_tag = req_tag;
		o_mark_dirty = hit & i_req_write;
		o_fill = (state == dcache_pkg::STATE_REFILL) & refill_last;
		o_fill_index = r_index;
		o_fill_tag = r_tag;
		o_advance = (state == dcache_pkg::STATE_FLUSH)
			| ((state == dcache_pkg::STATE_REFILL) & i_mem_rd_valid);
		o_load = (state == dcache_pkg::STATE_READY) & (next_state == dcache_pkg::STATE_FLUSH);
	end

	// Refill words take priority over stores
	always_comb
	begin
		o_bank_we = '0;
		if (state == dcache_pkg::STATE_READY)
		begin
			o_bank_wdata = i_req_wdata;
			o_bank_waddr = req_index;
			if (hit && i_req_write)
				o_bank_we[req_offset] = 1'b1;
			if (next_state == dcache_pkg::STATE_FLUSH)
				o_bank_raddr = req_index;
			else
				o_bank_raddr = next_index;
		end
		else
		begin
			o_bank_wdata = i_mem_rd_data;
			o_bank_waddr = r_index;
			if ((state == dcache_pkg::STATE_REFILL) && i_mem_rd_valid)
				o_bank_we = i_beat_select;
			if (next_state == dcache_pkg::STATE_READY)
				o_bank_raddr = next_index;
			else
				o_bank_raddr = r_index;
		end
	end

	always_comb
	begin
		o_mem_wr_go = o_load;
		o_mem_wr_base = {i_victim_tag, req_index, {LOW_BITS{1'b0}}};
		o_mem_wr_valid = state == dcache_pkg::STATE_FLUSH;
		o_mem_rd_go = (state != dcache_pkg::STATE_REFILL)
			& (next_state == dcache_pkg::STATE_REFILL);
		if (state == dcache_pkg::STATE_READY)
			o_mem_rd_base = {req_tag, req_index, {LOW_BITS{1'b0}}};
		else
			o_mem_rd_base = {r_tag, r_index, {LOW_BITS{1'b0}}};
	end

	rd_go_when_done: assert property (@(posedge clk) disable iff (!rst_n)
		o_mem_rd_go |-> i_mem_rd_done)
		else $error("%m read burst issued while memory busy");

	wr_go_when_done: assert property (@(posedge clk) disable iff (!rst_n)
		o_mem_wr_go |-> i_mem_wr_done)
		else $error("%m write burst issued while memory busy");

	state_legal: assert property (@(posedge clk) disable iff (!rst_n)
		state inside {dcache_pkg::STATE_READY, dcache_pkg::STATE_FLUSH,
			dcache_pkg::STATE_WAIT, dcache_pkg::STATE_REFILL})
		else $error("%m illegal miss state");

endmodule

//--- source/dcache_top.sv
// Direct-mapped write-back data cache
`timescale 1ns/1ps

module dcache_top (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_req_valid,
	input  logic               i_req_write,
	input  dcache_pkg::addr_t  i_req_addr,
	input  dcache_pkg::addr_t  i_req_addr_next,
	input  dcache_pkg::word_t  i_req_wdata,
	output logic               o_resp_valid,
	output dcache_pkg::word_t  o_resp_rdata,
	output logic               o_mem_rd_go,
	output dcache_pkg::addr_t  o_mem_rd_base,
	input  logic               i_mem_rd_done,
	input  logic               i_mem_rd_valid,
	input  dcache_pkg::word_t  i_mem_rd_data,
	output logic               o_mem_wr_go,
	output dcache_pkg::addr_t  o_mem_wr_base,
	input  logic               i_mem_wr_done,
	output logic               o_mem_wr_valid,
	output dcache_pkg::word_t  o_mem_wr_data
);

	dcache_pkg::index_t tag_index, tag_raddr, fill_index;
	dcache_pkg::index_t bank_waddr, bank_raddr;
	dcache_pkg::tag_t req_tag, victim_tag, fill_tag;
	dcache_pkg::beat_t beat_select, bank_we;
	dcache_pkg::word_t bank_wdata;
	dcache_pkg::word_t bank_rdata [dcache_pkg::LINE_WORDS];
	dcache_pkg::offset_t req_offset;
	logic match, victim_dirty, mark_dirty, fill;
	logic advance, load, beat_last;

	dcache_ctrl u_ctrl (
		.clk,
		.rst_n,
		.i_req_valid,
		.i_req_write,
		.i_req_addr,
		.i_req_addr_next,
		.i_req_wdata,
		.i_match        (match),
		.i_victim_dirty (victim_dirty),
		.i_victim_tag   (victim_tag),
		.i_beat_last    (beat_last),
		.i_beat_select  (beat_select),
		.i_mem_rd_done,
		.i_mem_rd_valid,
		.i_mem_rd_data,
		.i_mem_wr_done,
		.o_resp_valid,
		.o_index        (tag_index),
		.o_raddr        (tag_raddr),
		.o_tag          (req_tag),
		.o_mark_dirty   (mark_dirty),
		.o_fill         (fill),
		.o_fill_index   (fill_index),
		.o_fill_tag     (fill_tag),
		.o_advance      (advance),
		.o_load         (load),
		.o_bank_we      (bank_we),
		.o_bank_waddr   (bank_waddr),
		.o_bank_raddr   (bank_raddr),
		.o_bank_wdata   (bank_wdata),
		.o_mem_rd_go,
		.o_mem_rd_base,
		.o_mem_wr_go,
		.o_mem_wr_base,
		.o_mem_wr_valid
	);

	// Beat number is not needed at this level
	line_beat_counter u_beat (
		.clk,
		.rst_n,
		.i_advance (advance),
		.o_select  (beat_select),
		.o_beat    (),
		.o_last    (beat_last)
	);

	dcache_flush_buffer u_flush (
		.clk,
		.i_load (load),
		.i_line (bank_rdata),
		.o_word (o_mem_wr_data)
	);

	dcache_tag_store u_tags (
		.clk,
		.rst_n,
		.i_raddr        (tag_raddr),
		.i_index        (tag_index),
		.i_tag          (req_tag),
		.i_mark_dirty   (mark_dirty),
		.i_fill         (fill),
		.i_fill_index   (fill_index),
		.i_fill_tag     (fill_tag),
		.o_match        (match),
		.o_victim_dirty (victim_dirty),
		.o_victim_tag   (victim_tag)
	);

	// One bank per word of a line
	for (genvar g = 0; g < dcache_pkg::LINE_WORDS; g++)
	begin : g_data_bank
		cache_bank #(
			.payload_t (dcache_pkg::word_t)
		) u_data_bank (
			.clk,
			.i_we    (bank_we[g]),
			.i_waddr (bank_waddr),
			.i_raddr (bank_raddr),
			.i_wdata (bank_wdata),
			.o_rdata (bank_rdata[g])
		);
	end

	assign req_offset = i_req_addr[2 +: dcache_pkg::OFFSET_WIDTH];
	assign o_resp_rdata = bank_rdata[req_offset];

endmodule

//--- tb/dcache_mem_model.sv
// Behavioral main memory
`timescale 1ns/1ps

module dcache_mem_model #(
	parameter int MAX_GAP = 3
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_rd_go,
	input  dcache_pkg::addr_t  i_rd_base,
	output logic               o_rd_done,
	output logic               o_rd_valid,
	output dcache_pkg::word_t  o_rd_data,
	input  logic               i_wr_go,
	input  dcache_pkg::addr_t  i_wr_base,
	output logic               o_wr_done,
	input  logic               i_wr_valid,
	input  dcache_pkg::word_t  i_wr_data
);

	localparam int WORDS = 1 << (dcache_pkg::ADDR_WIDTH - 2);

	dcache_pkg::word_t mem [WORDS];
	integer seed = 32'hc727f865;
	int rd_ptr;
	int rd_count;
	int rd_gap;
	int wr_ptr;
	int wr_count;
	logic rd_busy;

	// Read burst with random gaps between words
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_rd_done <= 1'b1;
			o_rd_valid <= 1'b0;
			o_rd_data <= '0;
			rd_busy <= 1'b0;
			rd_ptr <= 0;
			rd_count <= 0;
			rd_gap <= 0;
		end
		else
		begin
			o_rd_valid <= 1'b0;
			if (i_rd_go)
			begin
				rd_busy <= 1'b1;
				o_rd_done <= 1'b0;
				rd_ptr <= int'(i_rd_base[dcache_pkg::ADDR_WIDTH - 1 : 2]);
				rd_count <= 0;
				rd_gap <= $unsigned($random(seed)) % (MAX_GAP + 1);
			end
			else if (rd_busy)
			begin
				if (rd_count == dcache_pkg::LINE_WORDS)
				begin
					rd_busy <= 1'b0;
					o_rd_done <= 1'b1;
				end
				else if (rd_gap != 0)
					rd_gap <= rd_gap - 1;
				else
				begin
					o_rd_valid <= 1'b1;
					o_rd_data <= mem[rd_ptr + rd_count];
					rd_count <= rd_count + 1;
					rd_gap <= $unsigned($random(seed)) % (MAX_GAP + 1);
				end
			end
		end
	end

	// Write burst, preload pattern set at reset
	always @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			o_wr_done <= 1'b1;
			wr_ptr <= 0;
			wr_count <= 0;
			for (int i = 0; i < WORDS; i++)
				mem[i] <= {dcache_pkg::addr_t'(i << 2) ^ 16'h5a3c,
					~dcache_pkg::addr_t'(i << 2)};
		end
		else if (i_wr_go)
		begin
			o_wr_done <= 1'b0;
			wr_ptr <= int'(i_wr_base[dcache_pkg::ADDR_WIDTH - 1 : 2]);
			wr_count <= 0;
		end
		else if (i_wr_valid)
		begin
			mem[wr_ptr + wr_count] <= i_wr_data;
			wr_count <= wr_count + 1;
			if (wr_count == dcache_pkg::LINE_WORDS - 1)
				o_wr_done <= 1'b1;
		end
	end

endmodule

//--- tb/tb_dcache.sv
// Data cache testbench
`timescale 1ns/1ps

module tb_dcache;

	localparam int CLK_PERIOD = 20;
	localparam int MAX_GAP = 3;
	localparam int NUM_RANDOM = 200;
	localparam int NUM_REQS = NUM_RANDOM + 8;
	localparam int LOW_BITS = dcache_pkg::OFFSET_WIDTH + 2;
	// Worst miss covers flush, write wait, slowest refill and the idle cycle
	localparam int MISS_CYCLES = 2 * dcache_pkg::LINE_WORDS + 4
		+ dcache_pkg::LINE_WORDS * (MAX_GAP + 1) + 2;
	localparam int WATCHDOG_CYCLES = NUM_REQS * MISS_CYCLES + 50;

	logic clk;
	logic rst_n;
	logic req_valid;
	logic req_write;
	dcache_pkg::addr_t req_addr;
	dcache_pkg::addr_t req_addr_next;
	dcache_pkg::word_t req_wdata;
	logic resp_valid;
	dcache_pkg::word_t resp_rdata;
	logic mem_rd_go;
	logic mem_rd_done;
	logic mem_rd_valid;
	dcache_pkg::addr_t mem_rd_base;
	dcache_pkg::word_t mem_rd_data;
	logic mem_wr_go;
	logic mem_wr_done;
	logic mem_wr_valid;
	dcache_pkg::addr_t mem_wr_base;
	dcache_pkg::word_t mem_wr_data;

	// Expected cache contents and memory image
	logic [dcache_pkg::NUM_LINES - 1 : 0] line_valid = '0;
	logic [dcache_pkg::NUM_LINES - 1 : 0] line_dirty = '0;
	dcache_pkg::tag_t line_tag [dcache_pkg::NUM_LINES];
	dcache_pkg::word_t shadow [1 << (dcache_pkg::ADDR_WIDTH - 2)];
	logic [(1 << (dcache_pkg::ADDR_WIDTH - 2)) - 1 : 0] written = '0;
	dcache_pkg::addr_t victim_base;
	integer seed = 32'hc727f865;
	int error_count = 0;
	int check_count = 0;
	int rd_bursts = 0;
	int wr_bursts = 0;
	int wr_beat = 0;

	dcache_top DUT (
		.clk,
		.rst_n,
		.i_req_valid     (req_valid),
		.i_req_write     (req_write),
		.i_req_addr      (req_addr),
		.i_req_addr_next (req_addr_next),
		.i_req_wdata     (req_wdata),
		.o_resp_valid    (resp_valid),
		.o_resp_rdata    (resp_rdata),
		.o_mem_rd_go     (mem_rd_go),
		.o_mem_rd_base   (mem_rd_base),
		.i_mem_rd_done   (mem_rd_done),
		.i_mem_rd_valid  (mem_rd_valid),
		.i_mem_rd_data   (mem_rd_data),
		.o_mem_wr_go     (mem_wr_go),
		.o_mem_wr_base   (mem_wr_base),
		.i_mem_wr_done   (mem_wr_done),
		.o_mem_wr_valid  (mem_wr_valid),
		.o_mem_wr_data   (mem_wr_data)
	);

	dcache_mem_model #(
		.MAX_GAP (MAX_GAP)
	) u_mem (
		.clk,
		.rst_n,
		.i_rd_go    (mem_rd_go),
		.i_rd_base  (mem_rd_base),
		.o_rd_done  (mem_rd_done),
		.o_rd_valid (mem_rd_valid),
		.o_rd_data  (mem_rd_data),
		.i_wr_go    (mem_wr_go),
		.i_wr_base  (mem_wr_base),
		.o_wr_done  (mem_wr_done),
		.i_wr_valid (mem_wr_valid),
		.i_wr_data  (mem_wr_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic dcache_pkg::word_t preload_word(input dcache_pkg::addr_t a);
		return {a ^ 16'h5a3c, ~a};
	endfunction

	// Last value stored at the address or the preload pattern
	function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
		if (written[a[dcache_pkg::ADDR_WIDTH - 1 : 2]])
			return shadow[a[dcache_pkg::ADDR_WIDTH - 1 : 2]];
		return preload_word(a);
	endfunction

	function automatic dcache_pkg::addr_t line_base(input dcache_pkg::addr_t a);
		return a & ~dcache_pkg::addr_t'((1 << LOW_BITS) - 1);
	endfunction

	task automatic compare_word(input string name, input dcache_pkg::word_t exp,
		input dcache_pkg::word_t act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic compare_addr(input string name, input dcache_pkg::addr_t exp,
		input dcache_pkg::addr_t act);
		check_count++;
		if (act !== exp)
		begin
			error_count++;
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic report_error(input string msg);
		error_count++;
		$display("Error at %0t: %s", $time, msg);
	endtask

	task automatic check_idle_outputs(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			check_count++;
			if (resp_valid || mem_rd_go || mem_wr_go || mem_wr_valid)
				report_error("DUT output active with no request pending");
		end
	endtask

	// One request after an idle cycle that announces its address
	task automatic run_request(input logic write, input dcache_pkg::addr_t addr,
		input dcache_pkg::word_t wdata);
		dcache_pkg::index_t idx;
		dcache_pkg::tag_t tag;
		logic exp_hit;
		logic exp_flush;
		logic prev_rd_valid;
		int rd_before;
		int wr_before;
		int cycles;
		idx = addr[LOW_BITS +: dcache_pkg::INDEX_WIDTH];
		tag = addr[dcache_pkg::ADDR_WIDTH - 1 -: dcache_pkg::TAG_WIDTH];
		exp_hit = line_valid[idx] && (line_tag[idx] == tag);
		exp_flush = !exp_hit && line_valid[idx] && line_dirty[idx];
		victim_base = {line_tag[idx], idx, {LOW_BITS{1'b0}}};
		rd_before = rd_bursts;
		wr_before = wr_bursts;
		cycles = 0;
		prev_rd_valid = 1'b0;
		@(posedge clk);
		req_valid <= 1'b0;
		req_addr_next <= addr;
		@(posedge clk);
		req_valid <= 1'b1;
		req_write <= write;
		req_addr <= addr;
		req_addr_next <= addr;
		req_wdata <= wdata;
		@(negedge clk);
		while (!resp_valid)
		begin
			cycles++;
			prev_rd_valid = mem_rd_valid;
			@(negedge clk);
		end
		if (write)
		begin
			shadow[addr[dcache_pkg::ADDR_WIDTH - 1 : 2]] = wdata;
			written[addr[dcache_pkg::ADDR_WIDTH - 1 : 2]] = 1'b1;
		end
		// Refilled line starts clean
		if (!exp_hit)
			line_dirty[idx] = 1'b0;
		if (write)
			line_dirty[idx] = 1'b1;
		line_valid[idx] = 1'b1;
		line_tag[idx] = tag;
		if (exp_hit && cycles != 0)
			report_error($sformatf("hit at %h took %0d extra cycles", addr, cycles));
		if (!exp_hit && cycles == 0)
			report_error($sformatf("miss at %h answered in its first cycle", addr));
		if (!exp_hit && !prev_rd_valid)
			report_error($sformatf("miss at %h not answered right after its refill", addr));
		if (rd_bursts - rd_before != (exp_hit ? 0 : 1))
			report_error($sformatf("wrong number of read bursts for %h", addr));
		if (wr_bursts - wr_before != (exp_flush ? 1 : 0))
			report_error($sformatf("wrong number of write bursts for %h", addr));
		if (exp_flush && wr_beat != dcache_pkg::LINE_WORDS)
			report_error($sformatf("flush for %h sent %0d words", addr, wr_beat));
	endtask

	// Few tags on two indices keep lines conflicting
	task automatic run_random_mix(input int count);
		dcache_pkg::tag_t tags [4];
		dcache_pkg::index_t idx;
		dcache_pkg::offset_t off;
		dcache_pkg::addr_t addr;
		logic write;
		tags = '{8'h12, 8'h55, 8'ha7, 8'h3c};
		for (int n = 0; n < count; n++)
		begin
			idx = dcache_pkg::index_t'(3 + $unsigned($random(seed)) % 2);
			off = dcache_pkg::offset_t'($unsigned($random(seed)) % 4);
			addr = {tags[$unsigned($random(seed)) % 4], idx, off, 2'b00};
			write = ($random(seed) & 1) != 0;
			run_request(write, addr, $random(seed));
		end
	endtask

	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (resp_valid && !req_write)
				compare_word("o_resp_rdata", expected_word(req_addr), resp_rdata);
			if (mem_rd_go)
			begin
				rd_bursts++;
				compare_addr("o_mem_rd_base", line_base(req_addr), mem_rd_base);
			end
			if (mem_wr_go)
			begin
				wr_bursts++;
				wr_beat = 0;
				compare_addr("o_mem_wr_base", victim_base, mem_wr_base);
			end
			if (mem_wr_valid)
			begin
				compare_word("o_mem_wr_data",
					expected_word(victim_base + dcache_pkg::addr_t'(wr_beat << 2)),
					mem_wr_data);
				wr_beat++;
			end
		end
	end

	initial
	begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_addr_next = '0;
		req_wdata = '0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
		check_idle_outputs(4);
		// Cold line
		run_request(1'b0, 16'h1230, '0);
		// Store followed by reads of the same word and its neighbor
		run_request(1'b1, 16'h1230, 32'hdeadbeef);
		run_request(1'b0, 16'h1230, '0);
		run_request(1'b0, 16'h1234, '0);
		// Other tag on the same index evicts the dirty line
		run_request(1'b0, 16'h5530, '0);
		run_request(1'b0, 16'h1230, '0);
		run_random_mix(NUM_RANDOM);
		@(posedge clk);
		req_valid <= 1'b0;
		repeat (4) @(posedge clk);
		$display("Summary: %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

endmodule

//--- sim.f
source/dcache_pkg.sv
source/cache_bank.sv
source/line_beat_counter.sv
source/dcache_flush_buffer.sv
source/dcache_tag_store.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/dcache_mem_model.sv
tb/tb_dcache.sv
